// ==== hdl/dmaPkg.sv ====
// SCSI DMA shared types
package dmaPkg;

    // CPU bus byte address
    typedef logic [31:0] busAddrT;

    // Bus data longword
    typedef logic [31:0] longT;

    // Peripheral data word
    typedef logic [15:0] wordT;

    // Longword count of one transfer
    typedef logic [15:0] countT;

    // Default longword slots in the FIFO, power of two
    localparam int FIFO_DEPTH = 8;

    // Bus master states
    typedef enum logic [2:0] {
        busIdle,     // Waiting for an active transfer
        busReq,      // Bus requested, waiting for grant
        addrPhase,   // Strobes up, first clock of a cycle
        waitTerm,    // Sampling dsack and sterm
        secondWord,  // Gap before the upper word cycle
        latchData,   // Cycle over, longword complete
        nextLong,    // Decide to go on or release
        xferDone     // Done pulse
    } smStateT;

endpackage

// ==== hdl/fifoCtlIf.sv ====
// FIFO strobes and flags
`timescale 1ns/100ps
interface fifoCtlIf;

    logic incFifo;    // Push latched longword
    logic decFifo;    // Pop longword sent on the bus
    logic fifoEmpty;  // No whole longword held
    logic fifoFull;   // No free slot

    modport sm (
        output incFifo,
        output decFifo,
        input  fifoEmpty,
        input  fifoFull
    );

    modport fifo (
        input  incFifo,
        input  decFifo,
        output fifoEmpty,
        output fifoFull
    );

endinterface

// ==== hdl/busLatchIf.sv ====
// Bus data path strobes
`timescale 1ns/100ps
interface busLatchIf;

    logic latchLow;   // Capture lower half of read data
    logic latchHigh;  // Capture upper half of read data
    logic driveLow;   // Lower lanes driven next clock
    logic driveHigh;  // Upper lanes driven next clock
    logic a1;         // Second word of a 16-bit port
    logic dataDir;    // Write data on the bus

    modport sm (
        output latchLow,
        output latchHigh,
        output driveLow,
        output driveHigh,
        output a1,
        output dataDir
    );

    modport path (
        input latchLow,
        input latchHigh,
        input driveLow,
        input driveHigh,
        input a1,
        input dataDir
    );

endinterface

// ==== hdl/cpuBusSm.sv ====
// CPU bus master state machine
`timescale 1ns/100ps
module cpuBusSm (
    input  logic       CLK,
    input  logic       nRESET,
    input  logic       dmaDir,
    input  logic       active,
    input  logic       lastLong,
    input  logic       bgrant,
    input  logic [1:0] dsack,
    input  logic       sterm,
    output logic       breq,
    output logic       bgack,
    output logic       as,
    output logic       ds,
    output logic       rw,
    output logic       size1,
    output logic       nextLong,
    output logic       done,
    fifoCtlIf.sm       fifo,
    busLatchIf.sm      lat
);

    dmaPkg::smStateT state;
    dmaPkg::smStateT nextState;
    logic half;         // Upper word cycle of a 16-bit port
    logic canMove;
    logic term32;
    logic term16;
    logic termAny;
    logic inCycle;
    logic nextInCycle;
    logic writeCycle;

    // Write needs a longword to send, read needs a free slot
    assign canMove = dmaDir ? !fifo.fifoEmpty : !fifo.fifoFull;

    assign term32  = sterm || (dsack == 2'b11);
    assign term16  = !sterm && (dsack == 2'b10);
    assign termAny = term32 || term16;

    always_comb begin
        nextState = state;
        case (state)
            dmaPkg::busIdle: begin
                if (active && canMove)
                    nextState = dmaPkg::busReq;
            end
            dmaPkg::busReq: begin
                if (!active)
                    nextState = dmaPkg::busIdle;
                else if (canMove && bgrant)
                    nextState = dmaPkg::addrPhase;
            end
            dmaPkg::addrPhase: begin
                nextState = dmaPkg::waitTerm;
            end
            dmaPkg::waitTerm: begin
                if (term16 && !half)
                    nextState = dmaPkg::secondWord;  // Port is only 16 bits wide
                else if (termAny)
                    nextState = dmaPkg::latchData;
            end
            dmaPkg::secondWord: begin
                nextState = dmaPkg::addrPhase;
            end
            dmaPkg::latchData: begin
                nextState = lastLong ? dmaPkg::xferDone : dmaPkg::nextLong;
            end
            dmaPkg::nextLong: begin
                // Give the bus back while the FIFO blocks
                nextState = canMove ? dmaPkg::addrPhase : dmaPkg::busReq;
            end
            dmaPkg::xferDone: begin
                nextState = dmaPkg::busIdle;
            end
            default: begin
                nextState = dmaPkg::busIdle;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            state <= dmaPkg::busIdle;
            half  <= 1'b0;
        end else begin
            state <= nextState;
            if (state == dmaPkg::waitTerm && term16 && !half)
                half <= 1'b1;
            else if (state == dmaPkg::latchData)
                half <= 1'b0;
        end
    end

    assign inCycle     = (state == dmaPkg::addrPhase) || (state == dmaPkg::waitTerm);
    assign nextInCycle = (nextState == dmaPkg::addrPhase) || (nextState == dmaPkg::waitTerm);
    assign writeCycle  = dmaDir && inCycle;

    // Bus control
    assign breq  = (state == dmaPkg::busReq) && active && canMove;
    assign bgack = state inside {dmaPkg::addrPhase, dmaPkg::waitTerm, dmaPkg::secondWord,
                                 dmaPkg::latchData, dmaPkg::nextLong};
    assign as    = inCycle;
    assign ds    = inCycle;
    assign rw    = !writeCycle;
    assign size1 = inCycle && half;  // Two bytes left after a word answer

    assign nextLong = state == dmaPkg::latchData;
    assign done     = state == dmaPkg::xferDone;

    // One FIFO strobe per finished longword
    assign fifo.incFifo = !dmaDir && (state == dmaPkg::latchData);
    assign fifo.decFifo = dmaDir && (state == dmaPkg::latchData);

    // Read capture on the terminating clock
    assign lat.latchHigh = !dmaDir && (state == dmaPkg::waitTerm) && !half && termAny;
    assign lat.latchLow  = !dmaDir && (state == dmaPkg::waitTerm) && (half ? termAny : term32);

    // Drivers register these, so they follow the next state
    assign lat.driveHigh = dmaDir && nextInCycle;
    assign lat.driveLow  = dmaDir && nextInCycle && !half;
    assign lat.a1        = half;
    assign lat.dataDir   = writeCycle;

    asNeedsBgack: assert property (@(posedge CLK) disable iff (!nRESET)
        as |-> bgack);

    oneFifoStrobe: assert property (@(posedge CLK) disable iff (!nRESET)
        !(fifo.incFifo && fifo.decFifo));

    noPushWhenFull: assert property (@(posedge CLK) disable iff (!nRESET)
        fifo.incFifo |-> !fifo.fifoFull);

    noPopWhenEmpty: assert property (@(posedge CLK) disable iff (!nRESET)
        fifo.decFifo |-> !fifo.fifoEmpty);

endmodule

// ==== hdl/xferCounter.sv ====
// Transfer address and longword counter
`timescale 1ns/100ps
module xferCounter #(
    parameter int countWidth = $bits(dmaPkg::countT)
) (
    input  logic            CLK,
    input  logic            nRESET,
    input  logic            start,
    input  dmaPkg::busAddrT startAddr,
    input  dmaPkg::countT   startCount,
    input  logic            nextLong,
    output dmaPkg::busAddrT busAddr,
    output logic            lastLong,
    output logic            active
);

    logic [countWidth-1:0] remaining;  // Longwords still to move

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            busAddr   <= '0;
            remaining <= '0;
            active    <= 1'b0;
        end else if (start) begin
            busAddr   <= {startAddr[31:2], 2'b00};  // Longword aligned
            remaining <= countWidth'(startCount);
            active    <= startCount != '0;
        end else if (nextLong) begin
            busAddr   <= busAddr + 32'd4;
            remaining <= remaining - 1'b1;
            if (lastLong)
                active <= 1'b0;
        end
    end

    assign lastLong = active && (remaining == countWidth'(1));

    // The bus side only finishes longwords of a loaded transfer
    nextOnlyWhenActive: assert property (@(posedge CLK) disable iff (!nRESET)
        nextLong |-> active);

endmodule

// ==== hdl/dmaFifo.sv ====
// Longword FIFO with word packing
`timescale 1ns/100ps
module dmaFifo #(
    parameter int depth = dmaPkg::FIFO_DEPTH
) (
    input  logic          CLK,
    input  logic          nRESET,
    input  logic          dmaDir,
    input  logic          periphWrite,
    input  dmaPkg::wordT  periphWData,
    input  logic          periphRead,
    output dmaPkg::wordT  periphRData,
    output logic          periphWordAvail,
    output logic          periphSpace,
    input  dmaPkg::longT  pushLong,
    output dmaPkg::longT  popLong,
    fifoCtlIf.fifo        fifo
);

    localparam int ptrWidth = $clog2(depth);
    localparam logic [ptrWidth:0] fullCount = depth[ptrWidth:0];

    dmaPkg::longT        store [depth];
    logic [ptrWidth-1:0] wrPtr;
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth:0]   fill;
    dmaPkg::wordT        upperWord;  // First word waits here
    logic                wordHeld;
    logic                rdHalf;     // Lower half goes out next
    logic                packWrite;
    logic                unpackRead;
    logic                push;
    logic                pop;
    dmaPkg::longT        pushData;

    assign fifo.fifoEmpty = fill == '0;
    assign fifo.fifoFull  = fill == fullCount;

    // Peripheral side only sees its own direction
    assign periphSpace     = dmaDir && !fifo.fifoFull;
    assign periphWordAvail = !dmaDir && !fifo.fifoEmpty;
    assign packWrite       = periphWrite && periphSpace;
    assign unpackRead      = periphRead && periphWordAvail;

    assign push     = dmaDir ? (packWrite && wordHeld) : fifo.incFifo;
    assign pop      = dmaDir ? fifo.decFifo : (unpackRead && rdHalf);
    assign pushData = dmaDir ? {upperWord, periphWData} : pushLong;

    assign popLong     = store[rdPtr];
    assign periphRData = rdHalf ? popLong[15:0] : popLong[31:16];

    always_ff @(posedge CLK) begin
        if (push)
            store[wrPtr] <= pushData;
        if (packWrite && !wordHeld)
            upperWord <= periphWData;
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            fill     <= '0;
            wordHeld <= 1'b0;
            rdHalf   <= 1'b0;
        end else begin
            if (push)
                wrPtr <= wrPtr + 1'b1;  // Wraps at depth
            if (pop)
                rdPtr <= rdPtr + 1'b1;
            if (push && !pop)
                fill <= fill + 1'b1;
            else if (pop && !push)
                fill <= fill - 1'b1;
            if (packWrite)
                wordHeld <= !wordHeld;
            if (unpackRead)
                rdHalf <= !rdHalf;
        end
    end

    fillInRange: assert property (@(posedge CLK) disable iff (!nRESET)
        fill <= fullCount);

endmodule

// ==== hdl/busDataPath.sv ====
// Bus data latches and drivers
`timescale 1ns/100ps
module busDataPath (
    input  logic         CLK,
    input  logic         nRESET,
    busLatchIf.path      lat,
    input  dmaPkg::longT popLong,
    input  dmaPkg::longT dataIn,
    output dmaPkg::longT pushLong,
    output dmaPkg::longT dataOut,
    output logic         dataOe
);

    dmaPkg::longT capture;     // Read longword being assembled
    dmaPkg::wordT lowCapture;
    dmaPkg::wordT upperLanes;
    dmaPkg::wordT lowerLanes;
    logic         oeHigh;
    logic         oeLow;

    // A 16-bit port answers on the upper lanes only
    assign lowCapture = (lat.a1 && !lat.dataDir) ? dataIn[31:16] : dataIn[15:0];

    always_ff @(posedge CLK) begin
        if (lat.latchHigh)
            capture[31:16] <= dataIn[31:16];
        if (lat.latchLow)
            capture[15:0] <= lowCapture;
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            oeHigh <= 1'b0;
            oeLow  <= 1'b0;
        end else begin
            oeHigh <= lat.driveHigh;
            oeLow  <= lat.driveLow;
        end
    end

    // Second word of a 16-bit write moves down to the upper lanes
    assign upperLanes = !oeHigh ? '0 :
                        (lat.a1 && lat.dataDir) ? popLong[15:0] : popLong[31:16];
    assign lowerLanes = oeLow ? popLong[15:0] : '0;

    assign dataOut  = {upperLanes, lowerLanes};
    assign dataOe   = oeHigh || oeLow;
    assign pushLong = capture;

endmodule

// ==== hdl/scsiDma.sv ====
// SCSI DMA engine top level
`timescale 1ns/100ps
module scsiDma #(
    parameter int fifoDepth  = dmaPkg::FIFO_DEPTH,
    parameter int countWidth = $bits(dmaPkg::countT)
) (
    input  logic            CLK,
    input  logic            nRESET,
    input  logic            start,
    input  logic            dmaDir,
    input  dmaPkg::busAddrT startAddr,
    input  dmaPkg::countT   startCount,
    output logic            done,
    input  logic            periphWrite,
    input  dmaPkg::wordT    periphWData,
    input  logic            periphRead,
    output dmaPkg::wordT    periphRData,
    output logic            periphWordAvail,
    output logic            periphSpace,
    output logic            breq,
    output logic            bgack,
    output logic            as,
    output logic            ds,
    output logic            rw,
    output logic            size1,
    output dmaPkg::busAddrT addr,
    input  logic            bgrant,
    input  logic [1:0]      dsack,
    input  logic            sterm,
    output dmaPkg::longT    dataOut,
    output logic            dataOe,
    input  dmaPkg::longT    dataIn
);

    dmaPkg::busAddrT busAddr;
    dmaPkg::longT    pushLong;
    dmaPkg::longT    popLong;
    logic            lastLong;
    logic            active;
    logic            nextLong;

    fifoCtlIf  fifoLink ();
    busLatchIf latLink ();

    // Word select of a 16-bit port goes out on A1
    assign addr = {busAddr[31:2], latLink.a1, busAddr[0]};

    cpuBusSm sm0 (
        .CLK      (CLK),
        .nRESET   (nRESET),
        .dmaDir   (dmaDir),
        .active   (active),
        .lastLong (lastLong),
        .bgrant   (bgrant),
        .dsack    (dsack),
        .sterm    (sterm),
        .breq     (breq),
        .bgack    (bgack),
        .as       (as),
        .ds       (ds),
        .rw       (rw),
        .size1    (size1),
        .nextLong (nextLong),
        .done     (done),
        .fifo     (fifoLink.sm),
        .lat      (latLink.sm)
    );

    xferCounter #(.countWidth(countWidth)) counter0 (
        .CLK        (CLK),
        .nRESET     (nRESET),
        .start      (start),
        .startAddr  (startAddr),
        .startCount (startCount),
        .nextLong   (nextLong),
        .busAddr    (busAddr),
        .lastLong   (lastLong),
        .active     (active)
    );

    dmaFifo #(.depth(fifoDepth)) fifo0 (
        .CLK             (CLK),
        .nRESET          (nRESET),
        .dmaDir          (dmaDir),
        .periphWrite     (periphWrite),
        .periphWData     (periphWData),
        .periphRead      (periphRead),
        .periphRData     (periphRData),
        .periphWordAvail (periphWordAvail),
        .periphSpace     (periphSpace),
        .pushLong        (pushLong),
        .popLong         (popLong),
        .fifo            (fifoLink.fifo)
    );

    busDataPath path0 (
        .CLK      (CLK),
        .nRESET   (nRESET),
        .lat      (latLink.path),
        .popLong  (popLong),
        .dataIn   (dataIn),
        .pushLong (pushLong),
        .dataOut  (dataOut),
        .dataOe   (dataOe)
    );

endmodule

// ==== verification/memResponder.sv ====
// Bus slave memory model
`timescale 1ns/100ps
module memResponder #(
    parameter int memLongs = 64
) (
    input  logic            CLK,
    input  logic            nRESET,
    input  logic            breq,
    input  logic            as,
    input  logic            rw,
    input  dmaPkg::busAddrT addr,
    input  dmaPkg::longT    dataOut,
    input  logic            port16,
    input  logic            useSterm,
    input  logic [3:0]      waitStates,
    input  logic [3:0]      grantDelay,
    output logic            bgrant,
    output logic [1:0]      dsack,
    output logic            sterm,
    output dmaPkg::longT    dataIn
);

    localparam int idxWidth = $clog2(memLongs);

    dmaPkg::longT        mem [memLongs];
    logic [3:0]          waitCnt;
    logic [3:0]          grantCnt;
    logic [idxWidth-1:0] idx;
    logic                termNow;
    logic                respond;
    dmaPkg::longT        readData;

    assign idx     = addr[idxWidth+1:2];
    assign termNow = (dsack != 2'b00) || sterm;
    assign respond = as && !termNow && (waitCnt >= waitStates);

    // A word port answers on the upper lanes, lower lanes float
    assign readData = !port16 ? mem[idx] :
                      addr[1] ? {mem[idx][15:0], 16'hffff} : {mem[idx][31:16], 16'hffff};

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            bgrant   <= 1'b0;
            grantCnt <= '0;
        end else if (!breq) begin
            bgrant   <= 1'b0;
            grantCnt <= '0;
        end else if (grantCnt >= grantDelay) begin
            bgrant <= 1'b1;
        end else begin
            grantCnt <= grantCnt + 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            dsack   <= 2'b00;
            sterm   <= 1'b0;
            dataIn  <= '0;
            waitCnt <= '0;
        end else if (!as || termNow) begin
            dsack   <= 2'b00;  // One clock of termination
            sterm   <= 1'b0;
            waitCnt <= '0;
        end else if (!respond) begin
            waitCnt <= waitCnt + 1'b1;
        end else begin
            sterm  <= useSterm;
            dsack  <= useSterm ? 2'b00 : (port16 ? 2'b10 : 2'b11);
            dataIn <= readData;
        end
    end

    always @(posedge CLK) begin
        if (respond && !rw) begin
            if (!port16)
                mem[idx] <= dataOut;
            else if (addr[1])
                mem[idx][15:0] <= dataOut[31:16];
            else
                mem[idx][31:16] <= dataOut[31:16];
        end
    end

endmodule

// ==== verification/tbScsiDma.sv ====
// SCSI DMA testbench
`timescale 1ns/100ps
module tbScsiDma;

    localparam int PERIOD_NS   = 8;
    localparam int MAX_WAIT    = 3;
    localparam int GRANT_DELAY = 2;
    localparam int STALL       = 200;
    localparam int TOTAL_LONGS = 6 + 4 + 5 + 12;
    localparam int WORST_LONG  = 2 * (MAX_WAIT + 4) + GRANT_DELAY + 4;
    localparam int MARGIN      = 4;

    logic            CLK;
    logic            nRESET;
    logic            start;
    logic            dmaDir;
    dmaPkg::busAddrT startAddr;
    dmaPkg::countT   startCount;
    logic            done;
    logic            periphWrite;
    dmaPkg::wordT    periphWData;
    logic            periphRead;
    dmaPkg::wordT    periphRData;
    logic            periphWordAvail;
    logic            periphSpace;
    logic            breq;
    logic            bgack;
    logic            as;
    logic            ds;
    logic            rw;
    logic            size1;
    dmaPkg::busAddrT addr;
    logic            bgrant;
    logic [1:0]      dsack;
    logic            sterm;
    dmaPkg::longT    dataOut;
    logic            dataOe;
    dmaPkg::longT    dataIn;
    logic            port16;
    logic            useSterm;
    logic [3:0]      waitStates;
    logic [3:0]      grantDelay;

    logic [31:0]     lfsr = 32'h44af_73a8;
    dmaPkg::wordT    expWords[$];
    dmaPkg::busAddrT expAddr = '0;
    logic            secondHalf = 1'b0;
    logic            granted = 1'b0;
    logic            asLast = 1'b0;
    int              doneCount = 0;

    scsiDma dut0 (.*);

    memResponder mem0 (
        .CLK(CLK), .nRESET(nRESET), .breq(breq), .as(as), .rw(rw), .addr(addr),
        .dataOut(dataOut), .port16(port16), .useSterm(useSterm),
        .waitStates(waitStates), .grantDelay(grantDelay), .bgrant(bgrant),
        .dsack(dsack), .sterm(sterm), .dataIn(dataIn)
    );

    initial begin
        CLK = 1'b0;
        forever #(PERIOD_NS / 2) CLK = ~CLK;
    end

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32+x^22+x^2+x+1
            lfsr  = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    // First word on the peripheral side lands in the upper half
    function automatic dmaPkg::longT packPair(input dmaPkg::wordT first, input dmaPkg::wordT second);
        return {first, second};
    endfunction

    function automatic dmaPkg::wordT unpackWord(input dmaPkg::longT value, input bit second);
        return second ? value[15:0] : value[31:16];
    endfunction

    function automatic dmaPkg::longT fillPattern(input int index);
        logic [31:0] byteAddr;
        byteAddr = index << 2;
        return {byteAddr[31:16] ^ byteAddr[15:0] ^ 16'h5a3c, ~byteAddr[15:0]};
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic checkIdleBus();
        checkValue("breq", breq, 1'b0);
        checkValue("bgack", bgack, 1'b0);
        checkValue("as", as, 1'b0);
        checkValue("ds", ds, 1'b0);
        checkValue("dataOe", dataOe, 1'b0);
        checkValue("done", done, 1'b0);
        checkValue("rw", rw, 1'b1);
    endtask

    // Bus protocol, address sequence and peripheral read data
    always @(posedge CLK) begin
        if (nRESET) begin
            checkValue("ds", ds, as);  // Strobes move together
            if (as)
                checkValue("bgack", bgack, 1'b1);
            if (as && !asLast) begin
                checkValue("bus grant before as", granted, 1'b1);
                checkValue("addr", addr, expAddr);
                checkValue("rw", rw, !dmaDir);
                checkValue("size1", size1, secondHalf);
                checkValue("dataOe", dataOe, dmaDir);
            end
            if (as && (sterm || dsack[1])) begin
                expAddr    = expAddr + ((port16 || secondHalf) ? 2 : 4);
                secondHalf = port16 && !secondHalf;  // Word port needs a second cycle
            end
            if (bgrant)
                granted = 1'b1;
            else if (!bgack)
                granted = 1'b0;
            if (done)
                doneCount++;
            if (periphRead && periphWordAvail) begin
                if (expWords.size() == 0) begin
                    $display("Peripheral side delivered a word beyond the transfer");
                    $display("Result: FAILED");
                    $fatal(1, "Extra word");
                end else begin
                    checkValue("periphRData", periphRData, expWords.pop_front());
                end
            end
            asLast = as;
        end
    end

    task automatic runTransfer(input bit dir, input dmaPkg::busAddrT base,
                               input dmaPkg::countT count, input bit wide16,
                               input bit stermMode, input int stallCycles);
        dmaPkg::wordT sent[$];
        dmaPkg::longT value;
        int           first;
        int           fed;
        int           cycles;
        first = base >> 2;
        fed = 0;
        cycles = 0;
        expWords.delete();
        if (dir) begin
            for (int i = 0; i < 64; i++)
                mem0.mem[i] = fillPattern(i);
            for (int i = 0; i < 2 * count; i++)
                sent.push_back(dmaPkg::wordT'(randBits(16)));
        end else begin
            for (int i = 0; i < count; i++) begin
                value = randBits(32);
                mem0.mem[first + i] = value;
                expWords.push_back(unpackWord(value, 1'b0));
                expWords.push_back(unpackWord(value, 1'b1));
            end
        end
        @(negedge CLK);
        dmaDir = dir;
        port16 = wide16;
        useSterm = stermMode;
        doneCount = 0;
        expAddr = base;
        secondHalf = 1'b0;
        @(negedge CLK);
        start = 1'b1;
        startAddr = base;
        startCount = count;
        @(negedge CLK);
        start = 1'b0;
        while (doneCount == 0 || expWords.size() != 0) begin
            if (!as)
                waitStates = 4'(randBits(2));
            periphWrite = dir && periphSpace && (fed < sent.size());
            if (periphWrite) begin
                periphWData = sent[fed];
                fed++;
            end
            periphRead = !dir && periphWordAvail && (cycles >= stallCycles);
            if (stallCycles > 0 && cycles == stallCycles) begin
                // FIFO full, bus must be released
                checkValue("breq", breq, 1'b0);
                checkValue("bgack", bgack, 1'b0);
            end
            cycles++;
            @(negedge CLK);
        end
        periphWrite = 1'b0;
        periphRead = 1'b0;
        repeat (4) @(negedge CLK);
        checkValue("done pulses", doneCount, 1);
        if (dir) begin
            for (int i = 0; i < count; i++)
                checkValue($sformatf("mem[%0d]", first + i), mem0.mem[first + i],
                           packPair(sent[2 * i], sent[2 * i + 1]));
            checkValue($sformatf("mem[%0d]", first + count), mem0.mem[first + count],
                       fillPattern(first + count));
        end
    endtask

    initial begin
        #((TOTAL_LONGS * WORST_LONG * MARGIN + STALL + 100) * PERIOD_NS);
        $display("Watchdog expired before all transfers finished");
        $display("Result: FAILED");
        $fatal(1, "Timeout");
    end

    initial begin
        nRESET = 1'b0;
        start = 1'b0;
        dmaDir = 1'b0;
        startAddr = '0;
        startCount = '0;
        periphWrite = 1'b0;
        periphWData = '0;
        periphRead = 1'b0;
        port16 = 1'b0;
        useSterm = 1'b0;
        waitStates = '0;
        grantDelay = GRANT_DELAY;
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        checkIdleBus();
        nRESET = 1'b1;
        repeat (3) begin
            @(negedge CLK);
            checkIdleBus();
        end
        runTransfer(1'b1, 32'h40, 6, 1'b0, 1'b0, 0);     // Longword port, dsack
        runTransfer(1'b1, 32'h10, 4, 1'b1, 1'b0, 0);     // Word port
        runTransfer(1'b0, 32'h80, 5, 1'b0, 1'b1, 0);     // Synchronous sterm
        runTransfer(1'b0, 32'h20, 12, 1'b0, 1'b0, STALL);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
hdl/dmaPkg.sv
hdl/fifoCtlIf.sv
hdl/busLatchIf.sv
hdl/cpuBusSm.sv
hdl/xferCounter.sv
hdl/dmaFifo.sv
hdl/busDataPath.sv
hdl/scsiDma.sv
verification/memResponder.sv
verification/tbScsiDma.sv
